// ==== design/dbg_pkg.sv ====
////////////////////
// shared types and memory map of the debug subsystem
// imported by every RTL module of the trace controller corner
////////////////////
package dbg_pkg;

   typedef logic [15:0] conf_word_t; // one configuration word
   typedef logic [2:0]  conf_addr_t; // word address

   // flit type encoding as used on the 16 bit debug network
   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,
      FLIT_HEAD    = 2'b01,
      FLIT_LAST    = 2'b10
   } flit_type_t;

   typedef struct packed {
      flit_type_t ftype;
      logic [15:0] content;
   } flit_t; // 18 bits on the wire

   typedef enum logic {
      REQ_READ  = 1'b0,
      REQ_WRITE = 1'b1
   } req_op_t; // bit 15 of the address flit

   typedef struct packed {
      logic [4:0] dest;
      logic [2:0] pkt_class;
      logic [7:0] src;
   } head_t; // head flit content

   localparam int CONF_WORDS = 8;

   // memory map
   localparam conf_addr_t ADDR_VERSION  = 3'd0;
   localparam conf_addr_t ADDR_SYSID    = 3'd1;
   localparam conf_addr_t ADDR_MODCOUNT = 3'd2;
   localparam conf_addr_t ADDR_CTRL     = 3'd3; // self clearing
   localparam conf_addr_t ADDR_HALT_HI  = 3'd4;
   localparam conf_addr_t ADDR_HALT_LO  = 3'd5;
   localparam conf_addr_t ADDR_CLK_HI   = 3'd6;
   localparam conf_addr_t ADDR_CLK_LO   = 3'd7;

   // control word bits
   localparam int CTRL_STALL    = 0;
   localparam int CTRL_UNSTALL  = 1; // wins over stall
   localparam int CTRL_RESET    = 2;
   localparam int CTRL_SNAPSHOT = 3;
   localparam int CTRL_START    = 4;

   localparam logic [CONF_WORDS-1:0] NET_WRITABLE = 1 << ADDR_CTRL; // host may write ctrl only
   localparam logic [2:0] CONF_CLASS = 3'd2;
   localparam conf_word_t VERSION = 16'd0;

endpackage

// ==== design/conf_mem.sv ====
////////////////////
// eight word configuration register file
// network write/read port from the packet interface,
// per word local write port from the trace controller
////////////////////
module conf_mem (
   input  logic clk,
   input  logic rst,
   // network side
   input  logic net_we,
   input  dbg_pkg::conf_addr_t net_addr,
   input  dbg_pkg::conf_word_t net_wdata,
   output dbg_pkg::conf_word_t rdata,
   // local side
   input  logic [dbg_pkg::CONF_WORDS-1:0] loc_we,
   input  dbg_pkg::conf_word_t [dbg_pkg::CONF_WORDS-1:0] loc_wdata,
   output dbg_pkg::conf_word_t [dbg_pkg::CONF_WORDS-1:0] conf_words
);
   import dbg_pkg::*;

   conf_word_t [CONF_WORDS-1:0] mem; // register file
   logic [CONF_WORDS-1:0] net_hit;  // network write per word

   // network write hits only writable words, and none while the
   // controller loads its reset values
   always_comb begin
      for (int i = 0; i < CONF_WORDS; i++) begin
         net_hit[i] = net_we && !rst && NET_WRITABLE[i]
                      && (net_addr == conf_addr_t'(i));
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < CONF_WORDS; i++) begin
         if (net_hit[i]) begin
            mem[i] <= net_wdata; // host wins
         end else if (loc_we[i]) begin
            mem[i] <= loc_wdata[i];
         end
      end
   end

   assign rdata = mem[net_addr]; // async read
   assign conf_words = mem;      // full view for the controller

endmodule

// ==== design/dbgnoc_conf_if.sv ====
////////////////////
// debug network endpoint for configuration access
// takes 3 flit requests (head, address, data) addressed to node_id
// and answers reads with a 2 flit response
////////////////////
module dbgnoc_conf_if #(
   parameter logic [4:0] node_id = 5'd0
) (
   input  logic clk,
   input  logic rst,
   // requests from the network
   input  dbg_pkg::flit_t in_flit,
   input  logic in_valid,
   output logic in_ready,
   // responses to the network
   output dbg_pkg::flit_t out_flit,
   output logic out_valid,
   input  logic out_ready,
   // memory port
   output logic net_we,
   output dbg_pkg::conf_addr_t net_addr,
   output dbg_pkg::conf_word_t net_wdata,
   input  dbg_pkg::conf_word_t rdata
);
   import dbg_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ADDR,
      ST_DATA,
      ST_RESP_HEAD,
      ST_RESP_DATA
   } conf_state_t;

   conf_state_t state;
   logic rx_en;       // low until the cycle after reset
   logic accept;      // flit taken this cycle
   logic last_ok;     // in sequence last flit
   logic rd_hit;      // read for this node completes
   head_t hdr_in;
   head_t hdr_out;

   // request context
   logic for_me_q;    // dest and class matched
   logic [4:0] dest_q; // requester becomes response dest
   req_op_t op_q;
   conf_addr_t addr_q;
   conf_word_t rdata_q;

   assign hdr_in = head_t'(in_flit.content);
   assign in_ready = rx_en && (state inside {ST_IDLE, ST_ADDR, ST_DATA});
   assign accept = in_valid && in_ready;
   assign last_ok = accept && (state == ST_DATA) && (in_flit.ftype == FLIT_LAST);

   // memory access happens on the edge that takes the last flit
   assign net_we = last_ok && for_me_q && (op_q == REQ_WRITE);
   assign rd_hit = last_ok && for_me_q && (op_q == REQ_READ);
   assign net_addr = addr_q;
   assign net_wdata = in_flit.content;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         rx_en <= 1'b0;
      end else begin
         rx_en <= 1'b1;
         case (state)
            ST_IDLE: begin
               if (accept && in_flit.ftype == FLIT_HEAD) begin
                  state <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               if (accept) begin
                  state <= (in_flit.ftype == FLIT_PAYLOAD) ? ST_DATA : ST_IDLE;
               end
            end
            ST_DATA: begin
               if (rd_hit) begin
                  state <= ST_RESP_HEAD;
               end else if (accept) begin
                  state <= ST_IDLE; // write done, dropped or out of sequence
               end
            end
            ST_RESP_HEAD: begin
               if (out_ready) begin
                  state <= ST_RESP_DATA;
               end
            end
            ST_RESP_DATA: begin
               if (out_ready) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // packet context capture
   always_ff @(posedge clk) begin
      if (accept && state == ST_IDLE) begin
         for_me_q <= (hdr_in.dest == node_id) && (hdr_in.pkt_class == CONF_CLASS);
         dest_q <= hdr_in.src[4:0];
      end
      if (accept && state == ST_ADDR) begin
         op_q <= req_op_t'(in_flit.content[15]);
         addr_q <= in_flit.content[2:0];
      end
      if (rd_hit) begin
         rdata_q <= rdata; // hold the word for the response
      end
   end

   // response flits
   always_comb begin
      hdr_out = '{dest: dest_q, pkt_class: CONF_CLASS, src: {3'b000, node_id}};
      out_flit.ftype = FLIT_HEAD;
      out_flit.content = hdr_out;
      if (state == ST_RESP_DATA) begin
         out_flit.ftype = FLIT_LAST;
         out_flit.content = rdata_q;
      end
   end

   assign out_valid = (state == ST_RESP_HEAD) || (state == ST_RESP_DATA);

endmodule

// ==== design/clk_perf_counters.sv ====
////////////////////
// saturating system clock and halted cycle counters
// snapshot restarts both from zero
////////////////////
module clk_perf_counters #(
   parameter int count_width = 32
) (
   input  logic clk,
   input  logic rst,
   input  logic sys_clk_is_halted,
   input  logic snapshot,
   output logic [count_width-1:0] clk_count,
   output logic [count_width-1:0] halt_count
);

   logic frozen; // one counter hit all ones

   // freeze both together so halt/clk ratio stays valid
   assign frozen = (&clk_count) || (&halt_count);

   always_ff @(posedge clk) begin
      if (rst) begin
         clk_count <= '0;
         halt_count <= '0;
      end else if (snapshot) begin
         clk_count <= '0; // restart after readout
         halt_count <= '0;
      end else if (!frozen) begin
         clk_count <= clk_count + 1'b1;
         if (sys_clk_is_halted) begin
            halt_count <= halt_count + 1'b1;
         end
      end
   end

endmodule

// ==== design/tcm.sv ====
////////////////////
// trace controller
// fills the id words, clears the control word each cycle,
// decodes control bits into CPU controls and counter snapshots
////////////////////
module tcm #(
   parameter dbg_pkg::conf_word_t system_id = '0,
   parameter dbg_pkg::conf_word_t module_count = '0,
   parameter int count_width = 32
) (
   input  logic clk,
   input  logic rst,
   input  dbg_pkg::conf_word_t [dbg_pkg::CONF_WORDS-1:0] conf_words,
   output logic [dbg_pkg::CONF_WORDS-1:0] loc_we,
   output dbg_pkg::conf_word_t [dbg_pkg::CONF_WORDS-1:0] loc_wdata,
   output logic snapshot,
   input  logic [count_width-1:0] clk_count,
   input  logic [count_width-1:0] halt_count,
   output logic cpu_stall,
   output logic cpu_reset,
   output logic start_cpu
);
   import dbg_pkg::*;

   logic init_q;        // loads all words, follows reset
   conf_word_t ctrl;    // current control word
   logic [31:0] clk_ext;
   logic [31:0] halt_ext;

   assign ctrl = conf_words[ADDR_CTRL];
   assign snapshot = ctrl[CTRL_SNAPSHOT]; // one cycle, word self clears
   assign clk_ext = 32'(clk_count);       // zero extend to hi/lo pair
   assign halt_ext = 32'(halt_count);

   always_ff @(posedge clk) begin
      if (rst) begin
         init_q <= 1'b1;
      end else begin
         init_q <= 1'b0;
      end
   end

   // write enables
   always_comb begin
      loc_we = {CONF_WORDS{init_q}};
      loc_we[ADDR_CTRL] = 1'b1; // cleared every cycle
      loc_we[ADDR_HALT_HI] = init_q || snapshot;
      loc_we[ADDR_HALT_LO] = init_q || snapshot;
      loc_we[ADDR_CLK_HI] = init_q || snapshot;
      loc_we[ADDR_CLK_LO] = init_q || snapshot;
   end

   // write data, counters are zero while loading
   always_comb begin
      loc_wdata[ADDR_VERSION] = VERSION;
      loc_wdata[ADDR_SYSID] = system_id;
      loc_wdata[ADDR_MODCOUNT] = module_count;
      loc_wdata[ADDR_CTRL] = '0;
      loc_wdata[ADDR_HALT_HI] = halt_ext[31:16];
      loc_wdata[ADDR_HALT_LO] = halt_ext[15:0];
      loc_wdata[ADDR_CLK_HI] = clk_ext[31:16];
      loc_wdata[ADDR_CLK_LO] = clk_ext[15:0];
   end

   // CPU controls, one cycle behind the control word
   always_ff @(posedge clk) begin
      if (rst) begin
         cpu_stall <= 1'b0;
         cpu_reset <= 1'b0;
         start_cpu <= 1'b0;
      end else begin
         if (ctrl[CTRL_UNSTALL]) begin
            cpu_stall <= 1'b0; // unstall has priority
         end else if (ctrl[CTRL_STALL]) begin
            cpu_stall <= 1'b1;
         end
         cpu_reset <= ctrl[CTRL_RESET]; // pulse
         start_cpu <= ctrl[CTRL_START]; // pulse
      end
   end

endmodule

// ==== design/dbg_subsystem.sv ====
////////////////////
// debug subsystem top
// network endpoint, config memory, trace controller, counters
////////////////////
module dbg_subsystem #(
   parameter dbg_pkg::conf_word_t system_id = '0,
   parameter dbg_pkg::conf_word_t module_count = '0,
   parameter logic [4:0] node_id = 5'd0,
   parameter int count_width = 32
) (
   input  logic clk,
   input  logic rst,
   input  dbg_pkg::flit_t in_flit,
   input  logic in_valid,
   output logic in_ready,
   output dbg_pkg::flit_t out_flit,
   output logic out_valid,
   input  logic out_ready,
   input  logic sys_clk_is_halted,
   output logic cpu_stall,
   output logic cpu_reset,
   output logic start_cpu
);
   import dbg_pkg::*;

   logic net_we;
   conf_addr_t net_addr;
   conf_word_t net_wdata;
   conf_word_t rdata;
   logic [CONF_WORDS-1:0] loc_we;
   conf_word_t [CONF_WORDS-1:0] loc_wdata;
   conf_word_t [CONF_WORDS-1:0] conf_words;
   logic snapshot;
   logic [count_width-1:0] clk_count;
   logic [count_width-1:0] halt_count;

   dbgnoc_conf_if #(.node_id(node_id)) u_dbgnoc_conf_if (
      .clk(clk), .rst(rst),
      .in_flit(in_flit), .in_valid(in_valid), .in_ready(in_ready),
      .out_flit(out_flit), .out_valid(out_valid), .out_ready(out_ready),
      .net_we(net_we), .net_addr(net_addr), .net_wdata(net_wdata), .rdata(rdata)
   );

   conf_mem u_conf_mem (
      .clk(clk), .rst(rst),
      .net_we(net_we), .net_addr(net_addr), .net_wdata(net_wdata), .rdata(rdata),
      .loc_we(loc_we), .loc_wdata(loc_wdata), .conf_words(conf_words)
   );

   tcm #(
      .system_id(system_id), .module_count(module_count), .count_width(count_width)
   ) u_tcm (
      .clk(clk), .rst(rst), .conf_words(conf_words),
      .loc_we(loc_we), .loc_wdata(loc_wdata), .snapshot(snapshot),
      .clk_count(clk_count), .halt_count(halt_count),
      .cpu_stall(cpu_stall), .cpu_reset(cpu_reset), .start_cpu(start_cpu)
   );

   clk_perf_counters #(.count_width(count_width)) u_clk_perf_counters (
      .clk(clk), .rst(rst), .sys_clk_is_halted(sys_clk_is_halted),
      .snapshot(snapshot), .clk_count(clk_count), .halt_count(halt_count)
   );

endmodule

// ==== tests/dbg_subsystem_assert.sv ====
////////////////////
// concurrent checks on the network handshake and the CPU pulses
// bound into dbg_subsystem, fails counted for the testbench
////////////////////
module dbg_subsystem_assert (
   input logic clk,
   input logic rst,
   input dbg_pkg::flit_t out_flit,
   input logic out_valid,
   input logic out_ready,
   input logic in_ready,
   input logic cpu_reset,
   input logic start_cpu
);
   timeunit 1ns;
   timeprecision 100ps;

   int fails = 0; // read by the testbench at the end

   // response held until the network takes it
   out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_flit))
      else begin
         $error("response flit dropped or changed under back-pressure");
         fails++;
      end

   reset_pulse: assert property (@(posedge clk) disable iff (rst) cpu_reset |=> !cpu_reset)
      else begin
         $error("cpu_reset high for more than one cycle");
         fails++;
      end

   start_pulse: assert property (@(posedge clk) disable iff (rst) start_cpu |=> !start_cpu)
      else begin
         $error("start_cpu high for more than one cycle");
         fails++;
      end

   // one request in flight
   one_in_flight: assert property (@(posedge clk) disable iff (rst) out_valid |-> !in_ready)
      else begin
         $error("in_ready high while a response is pending");
         fails++;
      end

endmodule

bind dbg_subsystem dbg_subsystem_assert dbg_subsystem_assert_i (.*);

// ==== tests/tb_dbg_subsystem.sv ====
////////////////////
// testbench for the debug subsystem
// applies a table of network requests, checks responses and CPU controls
////////////////////
module tb_dbg_subsystem;
   timeunit 1ns;
   timeprecision 100ps;
   import dbg_pkg::*;

   typedef enum {OP_READ, OP_NONZERO, OP_EQUAL, OP_WRITE, OP_DROP_RD, OP_DROP_WR,
                 OP_WAIT, OP_HALT} op_t;
   typedef struct {
      string name;
      op_t op;
      logic [4:0] dest;
      logic [2:0] cls;
      conf_addr_t addr;
      conf_word_t data;  // write data, wait count, halt level, or second address
      conf_word_t exp;   // writes: stall in bit 8, reset pulses 7:4, start pulses 3:0
   } entry_t;

   localparam logic [4:0] NODE = 5'd5;
   localparam logic [7:0] SRC = 8'h2c; // host id, low 5 bits come back as dest

   logic clk, rst, in_valid, in_ready, out_valid, out_ready, sys_clk_is_halted;
   logic cpu_stall, cpu_reset, start_cpu;
   flit_t in_flit, out_flit;
   entry_t tests[$];
   logic [31:0] lfsr = 32'he50dff59;
   int test_err, failed, cycles, limit;

   dbg_subsystem #(.system_id(16'h5a17), .module_count(16'd3), .node_id(NODE),
                   .count_width(8)) dbg_subsystem_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // watchdog
   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout after %0d cycles, a request or response never completed", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // galois lfsr, one step per bit taken
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
      return b;
   endfunction

   task automatic add_entry(string name, op_t op, logic [4:0] dest, logic [2:0] cls,
                            conf_addr_t addr, conf_word_t data, conf_word_t exp);
      entry_t e;
      e = '{name, op, dest, cls, addr, data, exp};
      tests.push_back(e);
   endtask

   task automatic report_mismatch(string sig, conf_word_t got, conf_word_t exp);
      $display("MISMATCH t=%0t %s got %h expected %h", $time, sig, got, exp);
      test_err++;
   endtask

   task automatic send_flit(flit_type_t t, logic [15:0] c);
      @(negedge clk);
      in_flit = '{t, c};
      in_valid = 1'b1;
      while (!in_ready) @(negedge clk); // taken on the next rising edge
      @(posedge clk);
   endtask

   task automatic send_request(entry_t e, req_op_t rop);
      head_t h;
      h = '{e.dest, e.cls, SRC};
      send_flit(FLIT_HEAD, h);
      send_flit(FLIT_PAYLOAD, {rop, 12'h000, e.addr});
      send_flit(FLIT_LAST, e.data);
      @(negedge clk);
      in_valid = 1'b0;
      out_ready = 1'b0; // response head waits for the collector
   endtask

   // one response flit, out_ready dropped at random
   task automatic recv_flit(output flit_t f, output bit got);
      int n;
      got = 1'b0;
      n = 0;
      while (!got && n < 40) begin
         @(negedge clk);
         out_ready = lfsr_bit();
         got = out_valid && out_ready;
         f = out_flit;
         n++;
      end
   endtask

   task automatic read_word(entry_t e, conf_addr_t a, output conf_word_t v);
      flit_t hf, df;
      bit got_h, got_d;
      head_t h;
      e.addr = a;
      send_request(e, REQ_READ);
      recv_flit(hf, got_h);
      recv_flit(df, got_d);
      h = head_t'(hf.content);
      v = df.content;
      if (!got_h || !got_d) begin
         $display("t=%0t %s: no read response from the DUT", $time, e.name);
         test_err++;
      end else begin
         if (hf.ftype !== FLIT_HEAD)
            report_mismatch("out_flit.ftype", hf.ftype, FLIT_HEAD);
         if (h.pkt_class !== CONF_CLASS)
            report_mismatch("out_flit.pkt_class", h.pkt_class, CONF_CLASS);
         if (h.dest !== SRC[4:0])
            report_mismatch("out_flit.dest", h.dest, SRC[4:0]);
         if (h.src !== {3'b000, NODE})
            report_mismatch("out_flit.src", h.src, {3'b000, NODE});
         if (df.ftype !== FLIT_LAST)
            report_mismatch("out_flit.ftype", df.ftype, FLIT_LAST);
      end
   endtask

   initial begin
      conf_word_t v, w;
      int n, resp_cnt, reset_cnt, start_cnt;
      rst = 1'b1;
      in_valid = 1'b0;
      in_flit = '0;
      out_ready = 1'b0;
      sys_clk_is_halted = 1'b0;
      add_entry("rd_version", OP_READ, NODE, CONF_CLASS, ADDR_VERSION, 0, VERSION);
      add_entry("rd_sysid", OP_READ, NODE, CONF_CLASS, ADDR_SYSID, 0, 16'h5a17);
      add_entry("rd_modcount", OP_READ, NODE, CONF_CLASS, ADDR_MODCOUNT, 0, 16'd3);
      add_entry("wr_sysid_ro", OP_WRITE, NODE, CONF_CLASS, ADDR_SYSID, 16'h1234, 16'h000);
      add_entry("rd_sysid_kept", OP_READ, NODE, CONF_CLASS, ADDR_SYSID, 0, 16'h5a17);
      add_entry("wr_stall", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0001, 16'h100);
      add_entry("rd_ctrl_clear", OP_READ, NODE, CONF_CLASS, ADDR_CTRL, 0, 16'h0000);
      add_entry("wr_unstall", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0002, 16'h000);
      add_entry("wr_stall_again", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0001, 16'h100);
      add_entry("wr_both", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0003, 16'h000);
      add_entry("wr_reset", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0004, 16'h010);
      add_entry("wr_start", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0010, 16'h001);
      // halted low, two snapshots apart
      add_entry("snap_low_a", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0008, 16'h000);
      add_entry("wait_low", OP_WAIT, NODE, CONF_CLASS, 0, 16'd10, 0);
      add_entry("snap_low_b", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0008, 16'h000);
      add_entry("rd_halt_zero", OP_READ, NODE, CONF_CLASS, ADDR_HALT_LO, 0, 16'h0000);
      add_entry("rd_clk_nonzero", OP_NONZERO, NODE, CONF_CLASS, ADDR_CLK_LO, 0, 0);
      // halted high, counts match
      add_entry("halt_on", OP_HALT, NODE, CONF_CLASS, 0, 16'd1, 0);
      add_entry("snap_high_a", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0008, 16'h000);
      add_entry("wait_high", OP_WAIT, NODE, CONF_CLASS, 0, 16'd10, 0);
      add_entry("snap_high_b", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0008, 16'h000);
      add_entry("halt_eq_clk", OP_EQUAL, NODE, CONF_CLASS, ADDR_HALT_LO, ADDR_CLK_LO, 0);
      // long run into saturation
      add_entry("wait_sat", OP_WAIT, NODE, CONF_CLASS, 0, 16'd300, 0);
      add_entry("snap_sat", OP_WRITE, NODE, CONF_CLASS, ADDR_CTRL, 16'h0008, 16'h000);
      add_entry("rd_halt_sat", OP_READ, NODE, CONF_CLASS, ADDR_HALT_LO, 0, 16'h00ff);
      add_entry("rd_clk_sat", OP_READ, NODE, CONF_CLASS, ADDR_CLK_LO, 0, 16'h00ff);
      add_entry("drop_dest", OP_DROP_WR, 5'd6, CONF_CLASS, ADDR_CTRL, 16'h0001, 16'h000);
      add_entry("drop_class", OP_DROP_RD, NODE, 3'd1, ADDR_SYSID, 0, 16'h000);
      add_entry("rd_after_drop", OP_READ, NODE, CONF_CLASS, ADDR_SYSID, 0, 16'h5a17);
      limit = tests.size() * 40;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      foreach (tests[i]) begin
         test_err = 0;
         case (tests[i].op)
            OP_READ, OP_NONZERO, OP_EQUAL: begin
               read_word(tests[i], tests[i].addr, v);
               if (tests[i].op == OP_READ && v !== tests[i].exp)
                  report_mismatch("read data", v, tests[i].exp);
               if (tests[i].op == OP_NONZERO && (v === '0 || $isunknown(v))) begin
                  $display("t=%0t %s: clock count reads zero", $time, tests[i].name);
                  test_err++;
               end
               if (tests[i].op == OP_EQUAL) begin
                  read_word(tests[i], tests[i].data[2:0], w);
                  if (v !== w)
                     report_mismatch("halt_lo vs clk_lo", v, w);
               end
            end
            OP_WRITE, OP_DROP_WR, OP_DROP_RD: begin
               send_request(tests[i], tests[i].op == OP_DROP_RD ? REQ_READ : REQ_WRITE);
               n = (tests[i].op == OP_WRITE) ? 8 : 20; // drops watched longer
               resp_cnt = 0;
               reset_cnt = 0;
               start_cnt = 0;
               repeat (n) begin
                  @(negedge clk);
                  resp_cnt += out_valid;
                  reset_cnt += cpu_reset;
                  start_cnt += start_cpu;
               end
               if (resp_cnt != 0) begin
                  $display("t=%0t %s: response sent where none was due", $time, tests[i].name);
                  test_err++;
               end
               if (cpu_stall !== tests[i].exp[8])
                  report_mismatch("cpu_stall", cpu_stall, tests[i].exp[8]);
               if (reset_cnt != tests[i].exp[7:4])
                  report_mismatch("cpu_reset cycles", reset_cnt, tests[i].exp[7:4]);
               if (start_cnt != tests[i].exp[3:0])
                  report_mismatch("start_cpu cycles", start_cnt, tests[i].exp[3:0]);
            end
            OP_WAIT: repeat (tests[i].data) @(negedge clk);
            OP_HALT: begin
               @(negedge clk);
               sys_clk_is_halted = tests[i].data[0];
            end
         endcase
         $display("%-16s %s", tests[i].name, test_err ? "error" : "ok");
         if (test_err)
            failed++;
      end
      $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", tests.size(),
               tests.size() - failed, failed, dbg_subsystem_i.dbg_subsystem_assert_i.fails);
      if (failed == 0 && dbg_subsystem_i.dbg_subsystem_assert_i.fails == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
design/dbg_pkg.sv
design/conf_mem.sv
design/dbgnoc_conf_if.sv
design/clk_perf_counters.sv
design/tcm.sv
design/dbg_subsystem.sv
tests/dbg_subsystem_assert.sv
tests/tb_dbg_subsystem.sv
